// File: lk_pkg.sv
// Lucas-Kanade optical-flow front end shared widths, window length and stage structs
package lk_pkg;

    // ************************************************************************
    // Widths
    // ************************************************************************
    localparam int RAW_BITS     = 8;    // Pixel
    localparam int GRAD_BITS    = 10;   // Gradient and temporal difference
    localparam int PROD_BITS    = 20;   // Single LK product
    localparam int SUM_BITS     = 24;   // Eight products, no overflow
    localparam int SOLVE_BITS   = 50;   // Determinant and numerators
    localparam int WIN_LEN      = 8;    // Valid beats per window
    localparam int WIN_CNT_BITS = 3;

    typedef logic        [RAW_BITS-1:0]   raw_t;
    typedef logic signed [GRAD_BITS-1:0]  grad_val_t;
    typedef logic signed [PROD_BITS-1:0]  prod_val_t;
    typedef logic signed [SUM_BITS-1:0]   sum_val_t;
    typedef logic signed [SOLVE_BITS-1:0] solve_val_t;

    // ************************************************************************
    // Stage payloads
    // ************************************************************************

    // Neighbourhood of one pixel position, current frame plus previous centre
    typedef struct packed {
        raw_t centre;
        raw_t left;
        raw_t right;
        raw_t up;
        raw_t down;
        raw_t prev;     // Previous frame, same position
    } pix_win_t;

    typedef struct packed {
        grad_val_t gradx;
        grad_val_t grady;
        grad_val_t diff;    // Temporal
    } grad_t;

    typedef struct packed {
        prod_val_t gx2;
        prod_val_t gy2;
        prod_val_t gxy;
        prod_val_t ex;
        prod_val_t ey;
    } prod_t;

    // Window sums, same fields as prod_t
    typedef struct packed {
        sum_val_t gx2;
        sum_val_t gy2;
        sum_val_t gxy;
        sum_val_t ex;
        sum_val_t ey;
    } sum_t;

    typedef struct packed {
        solve_val_t det;
        solve_val_t u_num;
        solve_val_t v_num;
    } flow_t;

endpackage

// File: lk_grad.sv
// Gradient stage forming central differences and the temporal difference of a pixel
`timescale 1ns/1ps

module lk_grad (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  lk_pkg::pix_win_t in_pix,
    output logic             out_valid,
    output lk_pkg::grad_t    out_grad
);

    lk_pkg::grad_t grad_next;

    // Zero-extend a raw pixel into the signed gradient range
    function automatic lk_pkg::grad_val_t widen(input lk_pkg::raw_t pix);
        lk_pkg::grad_val_t w;
        w = lk_pkg::grad_val_t'(pix);
        return w;
    endfunction

    // ************************************************************************
    // Differences
    // ************************************************************************
    always_comb begin
        grad_next.gradx = widen(in_pix.right) - widen(in_pix.left);
        grad_next.grady = widen(in_pix.down) - widen(in_pix.up);
        grad_next.diff  = widen(in_pix.centre) - widen(in_pix.prev);  // Current minus previous
    end

    // Payload only loads on a valid beat
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_grad <= grad_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

// File: lk_products.sv
// Two-stage product stage forming the five Lucas-Kanade products from gradients
`timescale 1ns/1ps

module lk_products (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  lk_pkg::grad_t in_grad,
    output logic          out_valid,
    output lk_pkg::prod_t out_prod
);

    lk_pkg::grad_t     st0_grad;
    logic              st0_valid;

    lk_pkg::prod_val_t gx;     // Sign-extended operands
    lk_pkg::prod_val_t gy;
    lk_pkg::prod_val_t dt;

    // ************************************************************************
    // Stage 0, register gradients
    // ************************************************************************
    always_ff @(posedge clk) begin
        st0_grad <= in_grad;
    end

    always_comb begin
        gx = lk_pkg::prod_val_t'(st0_grad.gradx);
        gy = lk_pkg::prod_val_t'(st0_grad.grady);
        dt = lk_pkg::prod_val_t'(st0_grad.diff);
    end

    // ************************************************************************
    // Stage 1, products
    // ************************************************************************
    always_ff @(posedge clk) begin
        out_prod.gx2 <= gx * gx;
        out_prod.gy2 <= gy * gy;
        out_prod.gxy <= gx * gy;
        out_prod.ex  <= gx * dt;   // Gradient times temporal difference
        out_prod.ey  <= gy * dt;
    end

    // Valid walks both stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st0_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            st0_valid <= in_valid;
            out_valid <= st0_valid;
        end
    end

endmodule

// File: lk_window_accum.sv
// Window accumulator summing each product field over eight valid beats
`timescale 1ns/1ps

module lk_window_accum (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  lk_pkg::prod_t in_prod,
    output logic          out_valid,
    output lk_pkg::sum_t  out_sum
);

    lk_pkg::sum_t                    acc;       // Running sum of current window
    lk_pkg::sum_t                    acc_next;
    logic [lk_pkg::WIN_CNT_BITS-1:0] beat_cnt;
    logic                            last_beat;

    // ************************************************************************
    // Next running sum
    // ************************************************************************
    always_comb begin
        acc_next.gx2 = acc.gx2 + lk_pkg::sum_val_t'(in_prod.gx2);
        acc_next.gy2 = acc.gy2 + lk_pkg::sum_val_t'(in_prod.gy2);
        acc_next.gxy = acc.gxy + lk_pkg::sum_val_t'(in_prod.gxy);
        acc_next.ex  = acc.ex + lk_pkg::sum_val_t'(in_prod.ex);
        acc_next.ey  = acc.ey + lk_pkg::sum_val_t'(in_prod.ey);
    end

    assign last_beat = in_valid
                    && (beat_cnt == lk_pkg::WIN_CNT_BITS'(lk_pkg::WIN_LEN - 1));

    // ************************************************************************
    // Window control
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            beat_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= last_beat;   // One-cycle pulse
            if (last_beat) begin
                acc      <= '0;       // Restart with next valid beat
                beat_cnt <= '0;
            end else if (in_valid) begin
                acc      <= acc_next;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Completed window sums, held until the next window closes
    always_ff @(posedge clk) begin
        if (last_beat) begin
            out_sum <= acc_next;
        end
    end

endmodule

// File: lk_flow_solve.sv
// Two-stage 2x2 solver forming the determinant and Cramer numerators of the flow
`timescale 1ns/1ps

module lk_flow_solve (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  lk_pkg::sum_t  in_sum,
    output logic          out_valid,
    output lk_pkg::flow_t out_flow
);

    lk_pkg::solve_val_t gx2;    // Sign-extended sums
    lk_pkg::solve_val_t gy2;
    lk_pkg::solve_val_t gxy;
    lk_pkg::solve_val_t ex;
    lk_pkg::solve_val_t ey;

    // Cross products, stage 0
    lk_pkg::solve_val_t gx2_gy2;
    lk_pkg::solve_val_t gxy_gxy;
    lk_pkg::solve_val_t gxy_ey;
    lk_pkg::solve_val_t gy2_ex;
    lk_pkg::solve_val_t gxy_ex;
    lk_pkg::solve_val_t gx2_ey;
    logic               st0_valid;

    always_comb begin
        gx2 = lk_pkg::solve_val_t'(in_sum.gx2);
        gy2 = lk_pkg::solve_val_t'(in_sum.gy2);
        gxy = lk_pkg::solve_val_t'(in_sum.gxy);
        ex  = lk_pkg::solve_val_t'(in_sum.ex);
        ey  = lk_pkg::solve_val_t'(in_sum.ey);
    end

    // ************************************************************************
    // Stage 0, cross products
    // ************************************************************************
    always_ff @(posedge clk) begin
        gx2_gy2 <= gx2 * gy2;
        gxy_gxy <= gxy * gxy;
        gxy_ey  <= gxy * ey;
        gy2_ex  <= gy2 * ex;
        gxy_ex  <= gxy * ex;
        gx2_ey  <= gx2 * ey;
    end

    // ************************************************************************
    // Stage 1, determinant and numerators
    // ************************************************************************
    always_ff @(posedge clk) begin
        out_flow.det   <= gx2_gy2 - gxy_gxy;
        out_flow.u_num <= gxy_ey - gy2_ex;
        out_flow.v_num <= gxy_ex - gx2_ey;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st0_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            st0_valid <= in_valid;
            out_valid <= st0_valid;
        end
    end

endmodule

// File: lk_flow_top.sv
// Lucas-Kanade optical-flow front end chaining gradient, product, window and solve stages
`timescale 1ns/1ps

module lk_flow_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  lk_pkg::pix_win_t in_pix,
    output logic             out_valid,
    output lk_pkg::flow_t    out_flow
);

    logic          grad_valid;
    lk_pkg::grad_t grad;
    logic          prod_valid;
    lk_pkg::prod_t prod;
    logic          sum_valid;   // Pulses once per window
    lk_pkg::sum_t  sum;

    // ************************************************************************
    // Pipeline, 1 + 2 + 1 + 2 cycles
    // ************************************************************************
    lk_grad i_grad (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .out_valid (grad_valid),
        .out_grad  (grad)
    );

    lk_products i_products (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (grad_valid),
        .in_grad   (grad),
        .out_valid (prod_valid),
        .out_prod  (prod)
    );

    lk_window_accum i_window_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (prod_valid),
        .in_prod   (prod),
        .out_valid (sum_valid),
        .out_sum   (sum)
    );

    lk_flow_solve i_flow_solve (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sum_valid),
        .in_sum    (sum),
        .out_valid (out_valid),
        .out_flow  (out_flow)
    );

endmodule

// File: tb_lk_flow.sv
// Testbench for the Lucas-Kanade flow front end driven and checked from a stimulus file
`timescale 1ns/1ps

module tb_lk_flow;

    localparam int CLK_PERIOD = 8;
    localparam int LATENCY    = 6;      // Eighth beat edge to out_valid capture edge
    localparam int MAX_WAIT   = 200;    // Cycles allowed for one pulse

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    lk_pkg::pix_win_t in_pix;
    logic             out_valid;
    lk_pkg::flow_t    out_flow;

    lk_pkg::pix_win_t beats[$];
    int               win_mode[$];      // Zero for random idle gaps or one for back to back
    lk_pkg::flow_t    expected[$];
    int               last_edge[$];     // Edge that samples the eighth beat of each window

    int          cycle     = 0;
    int          pulse_cnt = 0;
    int          pass_cnt  = 0;
    int          fail_cnt  = 0;
    logic [15:0] lfsr      = 16'd15;
    bit          load_ok;
    bit          reset_ok;

    lk_flow_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .out_valid (out_valid),
        .out_flow  (out_flow)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Every high out_valid cycle after reset
    always @(negedge clk) begin
        if (rst_n && out_valid === 1'b1) begin
            pulse_cnt++;
        end
    end

    // ************************************************************************
    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    // ************************************************************************
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    task automatic random_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    // ************************************************************************
    // Stimulus file
    // ************************************************************************
    task automatic load_stim(output bit ok);
        int               fd;
        int               code;
        int               mode;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        lk_pkg::raw_t     px [6];
        lk_pkg::pix_win_t pix;
        longint           det;
        longint           u_num;
        longint           v_num;
        lk_pkg::flow_t    flow;
        ok = 1'b1;
        fd = $fopen("lk_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open lk_stim.txt for reading");
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(rest, fd);    // Comment text
            end else if (tag == "W") begin
                code = $fscanf(fd, "%d", mode);
                win_mode.push_back(mode);
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h %h %h %h %h %h", px[0], px[1], px[2], px[3],
                               px[4], px[5]);
                pix.centre = px[0];
                pix.left   = px[1];
                pix.right  = px[2];
                pix.up     = px[3];
                pix.down   = px[4];
                pix.prev   = px[5];
                beats.push_back(pix);
            end else if (tag == "E") begin
                code = $fscanf(fd, "%d %d %d", det, u_num, v_num);
                flow.det   = lk_pkg::solve_val_t'(det);
                flow.u_num = lk_pkg::solve_val_t'(u_num);
                flow.v_num = lk_pkg::solve_val_t'(v_num);
                expected.push_back(flow);
            end else begin
                $display("unknown line tag %s in lk_stim.txt", tag);
                ok = 1'b0;
            end
        end
        $fclose(fd);
        if (beats.size() != lk_pkg::WIN_LEN * win_mode.size()
                || expected.size() != win_mode.size()) begin
            $display("lk_stim.txt does not hold eight beats and one result per window");
            ok = 1'b0;
        end
    endtask

    // ************************************************************************
    // Driver
    // ************************************************************************
    task automatic drive_beat(input lk_pkg::pix_win_t pix);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_pix   = pix;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_pix   = {8'hA5, 8'h00, 8'hFF, 8'hFF, 8'h00, 8'h5A};  // Nonzero gradients to drop
    endtask

    task automatic drive_windows();
        int gap;
        for (int w = 0; w < win_mode.size(); w++) begin
            for (int b = 0; b < lk_pkg::WIN_LEN; b++) begin
                if (win_mode[w] == 0) begin
                    random_bits(2, gap);
                    repeat (gap) begin
                        drive_idle();
                    end
                end
                drive_beat(beats[w * lk_pkg::WIN_LEN + b]);
            end
            last_edge.push_back(cycle + 1);
        end
        drive_idle();
    endtask

    // ************************************************************************
    // Checker
    // ************************************************************************
    task automatic wait_for_pulse(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < MAX_WAIT) begin
            @(negedge clk);
            if (out_valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
    endtask

    task automatic check_windows();
        bit            seen;
        bit            ok;
        int            pulse_edge;
        int            prev_edge;
        string         verdict;
        lk_pkg::flow_t exp_flow;
        prev_edge = 0;
        for (int w = 0; w < expected.size(); w++) begin
            wait_for_pulse(seen);
            if (!seen) begin
                $display("window %0d: no out_valid pulse within %0d cycles", w, MAX_WAIT);
                fail_cnt += expected.size() - w;
                return;
            end
            ok         = 1'b1;
            pulse_edge = cycle + 1;   // Edge that captures this pulse
            exp_flow   = expected[w];
            if (out_flow.det !== exp_flow.det) begin
                $display("MISMATCH time=%0t signal=out_flow.det got=%0d expected=%0d",
                         $time, out_flow.det, exp_flow.det);
                ok = 1'b0;
            end
            if (out_flow.u_num !== exp_flow.u_num) begin
                $display("MISMATCH time=%0t signal=out_flow.u_num got=%0d expected=%0d",
                         $time, out_flow.u_num, exp_flow.u_num);
                ok = 1'b0;
            end
            if (out_flow.v_num !== exp_flow.v_num) begin
                $display("MISMATCH time=%0t signal=out_flow.v_num got=%0d expected=%0d",
                         $time, out_flow.v_num, exp_flow.v_num);
                ok = 1'b0;
            end
            if (w >= last_edge.size()) begin
                $display("window %0d: out_valid pulsed before its eighth beat was driven", w);
                ok = 1'b0;
            end else if (pulse_edge - last_edge[w] != LATENCY) begin
                $display("window %0d: out_valid came %0d cycles after the eighth beat, not %0d",
                         w, pulse_edge - last_edge[w], LATENCY);
                ok = 1'b0;
            end
            // Back-to-back windows follow the previous one without a gap
            if (w > 0 && win_mode[w] == 1 && pulse_edge - prev_edge != lk_pkg::WIN_LEN) begin
                $display("window %0d: pulse came %0d cycles after the previous one, not %0d",
                         w, pulse_edge - prev_edge, lk_pkg::WIN_LEN);
                ok = 1'b0;
            end
            prev_edge = pulse_edge;
            if (ok) begin
                pass_cnt++;
                verdict = "pass";
            end else begin
                fail_cnt++;
                verdict = "fail";
            end
            $display("window %0d: %s, det=%0d u_num=%0d v_num=%0d", w, verdict,
                     out_flow.det, out_flow.u_num, out_flow.v_num);
        end
    endtask

    // ************************************************************************
    // Main sequence
    // ************************************************************************
    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_pix   = '0;
        reset_ok = 1'b1;
        load_stim(load_ok);
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            #1;
            if (out_valid !== 1'b0) begin
                reset_ok = 1'b0;
            end
        end
        rst_n = 1'b1;
        if (reset_ok) begin
            pass_cnt++;
            $display("reset: pass, out_valid low");
        end else begin
            fail_cnt++;
            $display("reset: fail, out_valid was not low during reset");
        end
        if (!load_ok) begin
            fail_cnt++;
            $display("stimulus: fail, lk_stim.txt could not be used");
        end else begin
            fork
                drive_windows();
                check_windows();
            join
            repeat (2 * lk_pkg::WIN_LEN) begin   // Room for a stray pulse
                @(posedge clk);
            end
            if (pulse_cnt == expected.size()) begin
                pass_cnt++;
                $display("pulse count: pass, %0d single-cycle pulses", pulse_cnt);
            end else begin
                fail_cnt++;
                $display("pulse count: fail, %0d out_valid cycles for %0d windows",
                         pulse_cnt, expected.size());
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: lk_stim.txt
# W mode : window start, mode 0 random idle gaps, mode 1 back to back
# P centre left right up down prev : one beat, pixels in hex
# E det u_num v_num : expected result of the window, signed decimal
W 0
P 00 00 00 00 00 00
P 24 24 24 24 24 24
P 48 48 48 48 48 48
P 6C 6C 6C 6C 6C 6C
P 90 90 90 90 90 90
P B4 B4 B4 B4 B4 B4
P D8 D8 D8 D8 D8 D8
P FF FF FF FF FF FF
E 0 0 0
W 0
P 14 0A 1E 14 14 1E
P 1E 14 28 1E 1E 28
P 28 1E 32 28 28 32
P 32 28 3C 32 32 3C
P 3C 32 46 3C 3C 46
P 46 3C 50 46 46 50
P 50 46 5A 50 50 5A
P 5A 50 64 5A 5A 64
E 0 0 0
W 0
P 64 64 67 64 62 63
P 64 64 60 64 65 62
P 64 64 66 64 69 67
P 64 64 63 64 61 66
P 64 64 6A 64 66 63
P 64 64 64 64 60 61
P 64 64 69 64 65 65
P 64 64 62 64 67 60
E 6359 992 536
W 1
P 64 64 67 64 62 63
P 64 64 60 64 65 62
P 64 64 66 64 69 67
P 64 64 63 64 61 66
P 64 64 6A 64 66 63
P 64 64 64 64 60 61
P 64 64 69 64 65 65
P 64 64 62 64 67 60
E 6359 992 536
W 1
P 14 0A 1E 14 14 1E
P 1E 14 28 1E 1E 28
P 28 1E 32 28 28 32
P 32 28 3C 32 32 3C
P 3C 32 46 3C 3C 46
P 46 3C 50 46 46 50
P 50 46 5A 50 50 5A
P 5A 50 64 5A 5A 64
E 0 0 0
W 1
P FF 00 FF FF 00 00
P 00 FF 00 80 80 FF
P FF 00 FF FF 00 00
P 00 FF 00 80 80 FF
P FF 00 FF FF 00 00
P 00 FF 00 80 80 FF
P FF 00 FF FF 00 00
P 00 FF 00 80 80 FF
E 67652010000 -67652010000 0

// File: vlog.f
lk_pkg.sv
lk_grad.sv
lk_products.sv
lk_window_accum.sv
lk_flow_solve.sv
lk_flow_top.sv
tb_lk_flow.sv

// File: Makefile
# Verilator lint, build and simulation of the Lucas-Kanade flow front end

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_lk_flow
RTL_TOP   ?= lk_flow_top
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
